/* compile.f */
common/mtStagePkg.sv
common/laneResultIf.sv
verilog/replayRecordMerge.sv
mtStage/loadLane.sv
mtStage/storeLane.sv
mtStage/memTagAccessStage.sv
tests/mtStage_assert.sv
tests/mtChecker.sv
tests/tbMemTagAccess.sv

/* run.sh */
#!/bin/sh
# Builds the tag-access stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbMemTagAccess -f compile.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { echo "simulator stopped early"; echo "TESTBENCH FAILED"; } >> sim.log
cat sim.log
! grep -q "TESTBENCH FAILED" sim.log && grep -q "TESTBENCH PASSED" sim.log || exit 1

/* tests/tbMemTagAccess.sv */
`default_nettype none

/*
 * Testbench for the memory tag-access stage
 * Drives random load and store traffic, LSU responses and stage control
 * through five tests while the checker compares every cycle.
 */
module tbMemTagAccess import mtStagePkg::*; ();

    // 300 cycles budgeted per test
    localparam int TEST_CYCLES = 300;
    localparam int NUM_TESTS = 5;
    localparam int MAX_CYCLES = NUM_TESTS * TEST_CYCLES + 100;

    logic clk, rstN, stall, clear, flushLd, flushSt;
    logic ldValid, ldRegValid, stValid, stRegValid, stConflict;
    memOpType_e ldOp, stOp;
    logic [ADDR_W-1:0] ldAddr, stAddr;
    memSize_e ldSize, stSize;
    memMap_e ldMap, stMap;
    logic [TAG_W-1:0] ldTag, stTag, ldOutTag, stOutTag;
    logic ldForwarded, ldForwardMiss, ldMshrAllocated, ldMshrHit, ldMshrAddrHit, ldDcHit;
    logic ldOutValid, ldOutRegValid, executeLoad, cancelDcRead;
    logic stOutValid, stOutRegValid, executeStore, orderViolation;
    execState_e ldExecState, stExecState;
    logic ldRecordEntry, ldRecordAddrHit, stRecordEntry;
    logic [INDEX_SUBSET_BITS-1:0] ldRecordSubset, stRecordSubset;
    int errorCount, checkCount, testsRun, cycleCount;

    memTagAccessStage dut0 (.*);
    mtChecker checker0 (.*);
    bind memTagAccessStage mtStageAssert assert0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial cycleCount = 0;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic driveRandom(input int faultPct, input int conflictPct,
                               input int fencePct, input int ctrlPct);
        @(negedge clk);
        ldValid    = ($urandom_range(99) < 90);
        ldOp       = ($urandom_range(99) < fencePct) ? memOpFenceI : memOpLoad;
        ldAddr     = $urandom;
        ldSize     = memSize_e'($urandom_range(2));
        ldMap      = memMap_e'($urandom_range(99) < faultPct);
        ldRegValid = ($urandom_range(99) < 85);
        ldTag      = TAG_W'($urandom);
        {ldForwarded, ldForwardMiss, ldMshrAllocated, ldMshrHit, ldMshrAddrHit, ldDcHit}
            = 6'($urandom);
        stValid    = ($urandom_range(99) < 90);
        stOp       = memOpStore;
        stAddr     = $urandom;
        stSize     = memSize_e'($urandom_range(2));
        stMap      = memMap_e'($urandom_range(99) < faultPct);
        stRegValid = ($urandom_range(99) < 85);
        stTag      = TAG_W'($urandom);
        stConflict = ($urandom_range(99) < conflictPct);
        // Aligned addresses unless faults are wanted
        if (faultPct == 0) begin
            ldAddr[1:0] = 2'b00;
            stAddr[1:0] = 2'b00;
        end
        stall   = ($urandom_range(99) < ctrlPct);
        clear   = ($urandom_range(99) < ctrlPct / 2);
        flushLd = ($urandom_range(99) < ctrlPct / 2);
        flushSt = ($urandom_range(99) < ctrlPct / 2);
    endtask

    task automatic runTest(input string name, input int cycles, input int faultPct,
                           input int conflictPct, input int fencePct, input int ctrlPct);
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (cycles) driveRandom(faultPct, conflictPct, fencePct, ctrlPct);
        @(posedge clk);
        testsRun++;
        $display("Test %0d %s finished with %0d errors", testsRun, name,
                 errorCount - errorsBefore);
    endtask

    task automatic runResetTest();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (120) driveRandom(10, 30, 20, 10);
        @(negedge clk);
        rstN = 1'b0;
        repeat (3) driveRandom(10, 30, 20, 10);
        rstN = 1'b1;
        repeat (120) driveRandom(10, 30, 20, 10);
        @(posedge clk);
        testsRun++;
        $display("Test %0d mid-run reset finished with %0d errors", testsRun,
                 errorCount - errorsBefore);
    endtask

    initial begin
        void'($urandom(32'he216_a551));
        testsRun = 0;
        rstN = 1'b0;
        {stall, clear, flushLd, flushSt, ldValid, ldRegValid, stValid, stRegValid} = '0;
        {ldForwarded, ldForwardMiss, ldMshrAllocated, ldMshrHit, ldMshrAddrHit, ldDcHit} = '0;
        stConflict = 1'b0;
        ldOp = memOpLoad;
        stOp = memOpStore;
        {ldAddr, stAddr, ldTag, stTag} = '0;
        ldSize = sizeByte;
        stSize = sizeByte;
        ldMap = mapNormal;
        stMap = mapNormal;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        runTest("load hit paths", 250, 0, 0, 0, 0);
        runTest("faults", 250, 30, 30, 0, 0);
        runTest("store conflict and FENCE.I", 250, 0, 50, 50, 0);
        runTest("stall, clear and flush", 250, 10, 20, 20, 25);
        runResetTest();

        $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/mtChecker.sv */
`default_nettype none

/*
 * Tag-access stage checker
 * Shadows both lane registers and compares every DUT output with a
 * reference model once per cycle, just before the rising edge.
 */
module mtChecker import mtStagePkg::*; (
    input  wire logic                         clk, rstN, stall, clear, flushLd, flushSt,
    input  wire logic                         ldValid, ldRegValid, stValid, stRegValid,
    input  wire logic                         stConflict,
    input  wire memOpType_e                   ldOp, stOp,
    input  wire logic [ADDR_W-1:0]            ldAddr, stAddr,
    input  wire memSize_e                     ldSize, stSize,
    input  wire memMap_e                      ldMap, stMap,
    input  wire logic [TAG_W-1:0]             ldTag, stTag,
    input  wire logic                         ldForwarded, ldForwardMiss, ldMshrAllocated,
    input  wire logic                         ldMshrHit, ldMshrAddrHit, ldDcHit,
    input  wire logic                         ldOutValid, ldOutRegValid, executeLoad,
    input  wire logic                         cancelDcRead,
    input  wire logic                         stOutValid, stOutRegValid, executeStore,
    input  wire logic                         orderViolation,
    input  wire execState_e                   ldExecState, stExecState,
    input  wire logic [TAG_W-1:0]             ldOutTag, stOutTag,
    input  wire logic                         ldRecordEntry, ldRecordAddrHit, stRecordEntry,
    input  wire logic [INDEX_SUBSET_BITS-1:0] ldRecordSubset, stRecordSubset,
    output int                                errorCount,
    output int                                checkCount
);

    logic              heldLdValid, heldStValid;
    memOpType_e        heldLdOp, heldStOp;
    logic [ADDR_W-1:0] heldLdAddr, heldStAddr;
    memSize_e          heldLdSize, heldStSize;
    memMap_e           heldLdMap, heldStMap;
    logic              heldLdRegValid, heldStRegValid;
    logic [TAG_W-1:0]  heldLdTag, heldStTag;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldLdValid <= 1'b0;
            heldStValid <= 1'b0;
        end else if (!stall) begin
            heldLdValid <= ldValid;
            heldStValid <= stValid;
        end
    end

    // Op payload shadow, held while stalled
    always @(posedge clk) begin
        if (!stall) begin
            heldLdOp       <= ldOp;
            heldLdAddr     <= ldAddr;
            heldLdSize     <= ldSize;
            heldLdMap      <= ldMap;
            heldLdRegValid <= ldRegValid;
            heldLdTag      <= ldTag;
            heldStOp       <= stOp;
            heldStAddr     <= stAddr;
            heldStSize     <= stSize;
            heldStMap      <= stMap;
            heldStRegValid <= stRegValid;
            heldStTag      <= stTag;
        end
    end

    function automatic logic alignFault(input logic [1:0] low, input memSize_e size);
        return (size == sizeHalf && low[0]) || (size == sizeWord && low != 2'b00);
    endfunction

    function automatic void modelLoad(output logic upd, output logic regValid,
                                      output execState_e state, output logic cancel,
                                      output logic record);
        logic isLoad;
        isLoad = (heldLdOp == memOpLoad);
        upd    = heldLdValid && !stall && !clear && !flushLd;
        cancel = isLoad && ldForwarded;
        if (!isLoad)
            regValid = heldLdRegValid;
        else if (ldForwarded)
            regValid = heldLdRegValid && !ldForwardMiss;
        else if (ldMshrAllocated)
            regValid = heldLdRegValid && ldMshrHit;
        else if (ldMshrHit)
            regValid = heldLdRegValid;
        else
            regValid = heldLdRegValid && ldDcHit;
        if (!upd || !regValid)
            state = execNotFinished;
        else if (isLoad && !ldForwarded && ldMshrAllocated && !ldMshrHit)
            state = execRefetchThis;
        else if (heldLdOp == memOpFenceI)
            state = execRefetchNext;
        else if (isLoad && heldLdMap == mapIllegal)
            state = execFaultLoadViolation;
        else if (isLoad && alignFault(heldLdAddr[1:0], heldLdSize))
            state = execFaultLoadMisaligned;
        else
            state = execSuccess;
        record = upd && isLoad && !regValid;
    endfunction

    function automatic void modelStore(output logic upd, output execState_e state,
                                       output logic violation, output logic record);
        logic isStore;
        isStore   = (heldStOp == memOpStore);
        upd       = heldStValid && !stall && !clear && !flushSt;
        violation = upd && heldStRegValid && isStore && stConflict;
        // A fault wins over the refetch but the violation flag stays
        if (!upd || !heldStRegValid)
            state = execNotFinished;
        else if (isStore && heldStMap == mapIllegal)
            state = execFaultStoreViolation;
        else if (isStore && alignFault(heldStAddr[1:0], heldStSize))
            state = execFaultStoreMisaligned;
        else if (violation)
            state = execRefetchNext;
        else
            state = execSuccess;
        record = upd && isStore && !heldStRegValid;
    endfunction

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("error at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic compareOutputs();
        logic       ldUpd, ldRv, ldCancel, ldRec;
        logic       stUpd, stViol, stRec;
        execState_e ldState, stState;
        modelLoad(ldUpd, ldRv, ldState, ldCancel, ldRec);
        modelStore(stUpd, stState, stViol, stRec);
        checkField("ldOutValid", 32'(ldOutValid), 32'(ldUpd));
        checkField("ldOutRegValid", 32'(ldOutRegValid), 32'(ldRv));
        checkField("ldExecState", 32'(ldExecState), 32'(ldState));
        checkField("ldOutTag", 32'(ldOutTag), 32'(heldLdTag));
        checkField("executeLoad", 32'(executeLoad), 32'(ldUpd && heldLdOp == memOpLoad));
        checkField("cancelDcRead", 32'(cancelDcRead), 32'(ldCancel));
        checkField("ldRecordEntry", 32'(ldRecordEntry), 32'(ldRec));
        checkField("ldRecordAddrHit", 32'(ldRecordAddrHit), 32'(ldRec && ldMshrAddrHit));
        checkField("ldRecordSubset", 32'(ldRecordSubset), 32'(heldLdAddr[6:4]));
        checkField("stOutValid", 32'(stOutValid), 32'(stUpd));
        checkField("stOutRegValid", 32'(stOutRegValid), 32'(heldStRegValid));
        checkField("stExecState", 32'(stExecState), 32'(stState));
        checkField("stOutTag", 32'(stOutTag), 32'(heldStTag));
        checkField("executeStore", 32'(executeStore), 32'(stUpd && heldStOp == memOpStore));
        checkField("orderViolation", 32'(orderViolation), 32'(stViol));
        checkField("stRecordEntry", 32'(stRecordEntry), 32'(stRec));
        checkField("stRecordSubset", 32'(stRecordSubset), 32'(heldStAddr[6:4]));
    endtask

    // Inputs change on the falling edge, so outputs have settled 3 units later
    always begin
        @(negedge clk);
        #3;
        compareOutputs();
    end

endmodule

`default_nettype wire

/* tests/mtStage_assert.sv */
`default_nettype none

/*
 * Tag-access stage assertions
 * Bound into the DUT to watch reset behavior and output consistency.
 */
module mtStageAssert (
    input wire logic clk,
    input wire logic rstN,
    input wire logic ldOutValid, stOutValid, executeLoad, executeStore,
    input wire logic ldRecordEntry, stRecordEntry, ldRecordAddrHit, orderViolation,
    input wire logic ldOutRegValid, stOutRegValid
);

    // Nothing issues or records while the stage is in reset
    resetQuiet: assert property (@(posedge clk)
        !rstN |-> !(ldOutValid || stOutValid || executeLoad || executeStore
                    || ldRecordEntry || stRecordEntry || ldRecordAddrHit || orderViolation))
        else $error("valid, execute or record output active during reset");

    violationNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        orderViolation |-> stOutValid)
        else $error("order violation raised without a valid store");

    // A replay request only for an op whose data was not ready
    ldRecordNeedsMiss: assert property (@(posedge clk) disable iff (!rstN)
        ldRecordEntry |-> !ldOutRegValid)
        else $error("load record request while load register is valid");

    stRecordNeedsMiss: assert property (@(posedge clk) disable iff (!rstN)
        stRecordEntry |-> !stOutRegValid)
        else $error("store record request while store register is valid");

endmodule

`default_nettype wire

/* mtStage/memTagAccessStage.sv */
`default_nettype none

/*
 * Memory tag-access stage
 * One load lane and one store lane side by side, each resolving its op's
 * execution state one cycle after capture, plus the replay-record merger.
 */
module memTagAccessStage import mtStagePkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   stall,
    input  wire logic                   clear,

    // Load op
    input  wire logic                   ldValid,
    input  wire memOpType_e             ldOp,
    input  wire logic [ADDR_W-1:0]      ldAddr,
    input  wire memSize_e               ldSize,
    input  wire memMap_e                ldMap,
    input  wire logic                   ldRegValid,
    input  wire logic [TAG_W-1:0]       ldTag,
    input  wire logic                   flushLd,

    // LSU responses for the load
    input  wire logic                   ldForwarded,
    input  wire logic                   ldForwardMiss,
    input  wire logic                   ldMshrAllocated,
    input  wire logic                   ldMshrHit,
    input  wire logic                   ldMshrAddrHit,
    input  wire logic                   ldDcHit,

    // Store op
    input  wire logic                   stValid,
    input  wire memOpType_e             stOp,
    input  wire logic [ADDR_W-1:0]      stAddr,
    input  wire memSize_e               stSize,
    input  wire memMap_e                stMap,
    input  wire logic                   stRegValid,
    input  wire logic [TAG_W-1:0]       stTag,
    input  wire logic                   flushSt,
    input  wire logic                   stConflict,

    output logic                        ldOutValid,
    output logic                        ldOutRegValid,
    output execState_e                  ldExecState,
    output logic [TAG_W-1:0]            ldOutTag,
    output logic                        executeLoad,
    output logic                        cancelDcRead,

    output logic                        stOutValid,
    output logic                        stOutRegValid,
    output execState_e                  stExecState,
    output logic [TAG_W-1:0]            stOutTag,
    output logic                        executeStore,
    output logic                        orderViolation,

    // Replay-queue record requests
    output logic                        ldRecordEntry,
    output logic                        ldRecordAddrHit,
    output logic [INDEX_SUBSET_BITS-1:0] ldRecordSubset,
    output logic                        stRecordEntry,
    output logic [INDEX_SUBSET_BITS-1:0] stRecordSubset
);

    laneResultIf ldResult ();
    laneResultIf stResult ();

    loadLane loadLane0 (
        .clk           (clk),
        .rstN          (rstN),
        .stall         (stall),
        .clear         (clear),
        .flush         (flushLd),
        .valid         (ldValid),
        .op            (ldOp),
        .addr          (ldAddr),
        .size          (ldSize),
        .map           (ldMap),
        .regValid      (ldRegValid),
        .tag           (ldTag),
        .forwarded     (ldForwarded),
        .forwardMiss   (ldForwardMiss),
        .mshrAllocated (ldMshrAllocated),
        .mshrHit       (ldMshrHit),
        .mshrAddrHit   (ldMshrAddrHit),
        .dcHit         (ldDcHit),
        .outValid      (ldOutValid),
        .outRegValid   (ldOutRegValid),
        .execState     (ldExecState),
        .outTag        (ldOutTag),
        .executeLoad   (executeLoad),
        .cancelDcRead  (cancelDcRead),
        .result        (ldResult.lane)
    );

    storeLane storeLane0 (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .clear          (clear),
        .flush          (flushSt),
        .valid          (stValid),
        .op             (stOp),
        .addr           (stAddr),
        .size           (stSize),
        .map            (stMap),
        .regValid       (stRegValid),
        .tag            (stTag),
        .conflict       (stConflict),
        .outValid       (stOutValid),
        .outRegValid    (stOutRegValid),
        .execState      (stExecState),
        .outTag         (stOutTag),
        .executeStore   (executeStore),
        .orderViolation (orderViolation),
        .result         (stResult.lane)
    );

    replayRecordMerge replayRecordMerge0 (
        .ld              (ldResult.merge),
        .st              (stResult.merge),
        .ldRecordEntry   (ldRecordEntry),
        .ldRecordAddrHit (ldRecordAddrHit),
        .ldRecordSubset  (ldRecordSubset),
        .stRecordEntry   (stRecordEntry),
        .stRecordSubset  (stRecordSubset)
    );

endmodule

`default_nettype wire

/* mtStage/storeLane.sv */
`default_nettype none

/*
 * Store lane of the tag-access stage
 * Holds the store op, flags memory-order conflicts and store faults.
 */
module storeLane import mtStagePkg::*; (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              stall,
    input  wire logic              clear,
    input  wire logic              flush,

    input  wire logic              valid,
    input  wire memOpType_e        op,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire memSize_e          size,
    input  wire memMap_e           map,
    input  wire logic              regValid,
    input  wire logic [TAG_W-1:0]  tag,
    input  wire logic              conflict,

    output logic                   outValid,
    output logic                   outRegValid,
    output execState_e             execState,
    output logic [TAG_W-1:0]       outTag,
    output logic                   executeStore,
    output logic                   orderViolation,

    laneResultIf.lane              result
);

    logic              pipeValid;
    memOpType_e        pipeOp;
    logic [ADDR_W-1:0] pipeAddr;
    memSize_e          pipeSize;
    memMap_e           pipeMap;
    logic              pipeRegValid;
    logic [TAG_W-1:0]  pipeTag;

    logic              update;
    logic              isStore;
    execState_e        state;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOp       <= op;
            pipeAddr     <= addr;
            pipeSize     <= size;
            pipeMap      <= map;
            pipeRegValid <= regValid;
            pipeTag      <= tag;
        end
    end

    assign update  = pipeValid && !stall && !clear && !flush;
    assign isStore = (pipeOp == memOpStore);

    always_comb begin
        orderViolation = 1'b0;
        if (!update || !pipeRegValid) begin
            state = execNotFinished;
        end else if (isStore && conflict) begin
            // A younger load already read stale data
            state          = execRefetchNext;
            orderViolation = 1'b1;
        end else begin
            state = execSuccess;
        end

        // Fault overrides the refetch while the violation report stays for the predictor
        if ((state == execSuccess || state == execRefetchNext) && isStore) begin
            if (pipeMap == mapIllegal) begin
                state = execFaultStoreViolation;
            end else if (isMisaligned(pipeAddr[1:0], pipeSize)) begin
                state = execFaultStoreMisaligned;
            end
        end
    end

    assign outValid     = update;
    assign outRegValid  = pipeRegValid;
    assign execState    = state;
    assign outTag       = pipeTag;
    assign executeStore = update && isStore;

    assign result.update   = update;
    assign result.regValid = pipeRegValid;
    assign result.addr     = pipeAddr;
    assign result.addrHit  = 1'b0;
    assign result.isMemOp  = isStore;

endmodule

`default_nettype wire

/* mtStage/loadLane.sv */
`default_nettype none

/*
 * Load lane of the tag-access stage
 * Holds the load/FENCE.I op and resolves its register validity and
 * execution state from the LSU responses of the following cycle.
 */
module loadLane import mtStagePkg::*; (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              stall,
    input  wire logic              clear,
    input  wire logic              flush,

    input  wire logic              valid,
    input  wire memOpType_e        op,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire memSize_e          size,
    input  wire memMap_e           map,
    input  wire logic              regValid,
    input  wire logic [TAG_W-1:0]  tag,

    input  wire logic              forwarded,
    input  wire logic              forwardMiss,
    input  wire logic              mshrAllocated,
    input  wire logic              mshrHit,
    input  wire logic              mshrAddrHit,
    input  wire logic              dcHit,

    output logic                   outValid,
    output logic                   outRegValid,
    output execState_e             execState,
    output logic [TAG_W-1:0]       outTag,
    output logic                   executeLoad,
    output logic                   cancelDcRead,

    laneResultIf.lane              result
);

    logic              pipeValid;
    memOpType_e        pipeOp;
    logic [ADDR_W-1:0] pipeAddr;
    memSize_e          pipeSize;
    memMap_e           pipeMap;
    logic              pipeRegValid;
    logic [TAG_W-1:0]  pipeTag;

    logic              update;
    logic              isLoad;
    logic              isFenceI;
    logic              resolvedRegValid;
    execState_e        state;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= valid;
        end
    end

    // Op payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOp       <= op;
            pipeAddr     <= addr;
            pipeSize     <= size;
            pipeMap      <= map;
            pipeRegValid <= regValid;
            pipeTag      <= tag;
        end
    end

    assign update   = pipeValid && !stall && !clear && !flush;
    assign isLoad   = (pipeOp == memOpLoad);
    assign isFenceI = (pipeOp == memOpFenceI);

    // Where the load data comes from decides whether consumers may wake up
    always_comb begin
        cancelDcRead     = 1'b0;
        resolvedRegValid = pipeRegValid;
        if (isLoad) begin
            if (forwarded) begin
                // Store data wins, so the cache read must not allocate an MSHR
                cancelDcRead     = 1'b1;
                resolvedRegValid = pipeRegValid && !forwardMiss;
            end else if (mshrAllocated) begin
                resolvedRegValid = pipeRegValid && mshrHit;
            end else if (mshrHit) begin
                resolvedRegValid = pipeRegValid;
            end else begin
                resolvedRegValid = pipeRegValid && dcHit;
            end
        end
    end

    always_comb begin
        if (!update || !resolvedRegValid) begin
            state = execNotFinished;
        end else if (isLoad && !forwarded && mshrAllocated && !mshrHit) begin
            state = execRefetchThis;
        end else if (isFenceI) begin
            // Later ops may hold stale I-cache data
            state = execRefetchNext;
        end else begin
            state = execSuccess;
        end

        // Faults only on a load that otherwise completed
        if (state == execSuccess && isLoad) begin
            if (pipeMap == mapIllegal) begin
                state = execFaultLoadViolation;
            end else if (isMisaligned(pipeAddr[1:0], pipeSize)) begin
                state = execFaultLoadMisaligned;
            end
        end
    end

    assign outValid    = update;
    assign outRegValid = resolvedRegValid;
    assign execState   = state;
    assign outTag      = pipeTag;
    assign executeLoad = update && isLoad;

    assign result.update   = update;
    assign result.regValid = resolvedRegValid;
    assign result.addr     = pipeAddr;
    assign result.addrHit  = mshrAddrHit;
    assign result.isMemOp  = isLoad;

endmodule

`default_nettype wire

/* verilog/replayRecordMerge.sv */
`default_nettype none

/*
 * Replay-record merger
 * Raises a replay-queue record request for each lane whose memory op
 * could not produce valid data, with the line-index subset of its address.
 */
module replayRecordMerge import mtStagePkg::*; (
    laneResultIf.merge                   ld,
    laneResultIf.merge                   st,

    output logic                         ldRecordEntry,
    output logic                         ldRecordAddrHit,
    output logic [INDEX_SUBSET_BITS-1:0] ldRecordSubset,
    output logic                         stRecordEntry,
    output logic [INDEX_SUBSET_BITS-1:0] stRecordSubset
);

    // Missed ops wait in the replay queue until their line returns
    assign ldRecordEntry = ld.update && ld.isMemOp && !ld.regValid;
    assign stRecordEntry = st.update && st.isMemOp && !st.regValid;

    // MSHR address hit is only meaningful alongside a request
    assign ldRecordAddrHit = ldRecordEntry && ld.addrHit;

    assign ldRecordSubset = ld.addr[LINE_BYTE_BITS +: INDEX_SUBSET_BITS];
    assign stRecordSubset = st.addr[LINE_BYTE_BITS +: INDEX_SUBSET_BITS];

endmodule

`default_nettype wire

/* common/laneResultIf.sv */
`default_nettype none

/*
 * Lane result bundle
 * Carries one lane's resolved op state to the replay-record merger.
 */
interface laneResultIf import mtStagePkg::*; ();

    logic              update;
    logic              regValid;
    logic [ADDR_W-1:0] addr;
    logic              addrHit;
    logic              isMemOp;

    modport lane (
        output update,
        output regValid,
        output addr,
        output addrHit,
        output isMemOp
    );

    modport merge (
        input update,
        input regValid,
        input addr,
        input addrHit,
        input isMemOp
    );

endinterface

`default_nettype wire

/* common/mtStagePkg.sv */
`default_nettype none

/*
 * Memory tag-access stage definitions
 * Widths, line-address field positions, op and execution-state encodings
 * and the alignment check shared by both lanes.
 */
package mtStagePkg;

    localparam int ADDR_W = 32;
    localparam int LINE_BYTE_BITS = 4;
    // Line-index subset, right above the byte offset
    localparam int INDEX_SUBSET_BITS = 3;
    localparam int TAG_W = 6;

    typedef enum logic [1:0] {
        memOpLoad   = 2'd0,
        memOpFenceI = 2'd1,
        memOpStore  = 2'd2
    } memOpType_e;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSize_e;

    typedef enum logic [0:0] {
        mapNormal  = 1'b0,
        mapIllegal = 1'b1
    } memMap_e;

    typedef enum logic [3:0] {
        execNotFinished          = 4'd0,
        execSuccess              = 4'd1,
        execRefetchThis          = 4'd2,
        execRefetchNext          = 4'd3,
        execFaultLoadViolation   = 4'd4,
        execFaultLoadMisaligned  = 4'd5,
        execFaultStoreViolation  = 4'd6,
        execFaultStoreMisaligned = 4'd7
    } execState_e;

    // Only the two low address bits matter for alignment
    function automatic logic isMisaligned(input logic [1:0] lowAddr, input memSize_e size);
        logic misaligned;
        case (size)
            sizeHalf: misaligned = lowAddr[0];
            sizeWord: misaligned = |lowAddr;
            default:  misaligned = 1'b0;
        endcase
        return misaligned;
    endfunction

endpackage

`default_nettype wire
